// ==== backend_top.f ====
+incdir+common
common/pipeline_types.sv
hdl/decoder.sv
hdl/dispatch_queue.sv
hdl/regfile.sv
hdl/execute.sv
hdl/backend_top.sv
bench/backend_asserts.sv
bench/backend_tb.sv

// ==== bench/backend_asserts.sv ====
`include "backend_cfg.svh"

module backend_asserts #(
    parameter int DEPTH        = `BACKEND_QUEUE_DEPTH,
    parameter bit QUEUE_CHECKS = 1'b1
) (
    input logic       clk,
    input logic       rst_n_i,
    input logic [7:0] count_i,
    input logic       deq_i,
    input logic       not_empty_i,
    input logic       pause_i,
    input logic       commit_valid_i
);

    if (QUEUE_CHECKS) begin : g_queue

        count_in_range: assert property (
            @(posedge clk) disable iff (!rst_n_i) count_i <= 8'(DEPTH)
        ) else $error("dispatch queue count %0d is above the depth", count_i);

        no_deq_when_empty: assert property (
            @(posedge clk) disable iff (!rst_n_i) deq_i |-> not_empty_i
        ) else $error("dequeue while the dispatch queue is empty");

    end else begin : g_top

        // a paused cycle pops nothing, so the next commit slot stays empty
        no_commit_after_pause: assert property (
            @(posedge clk) disable iff (!rst_n_i) pause_i |=> !commit_valid_i
        ) else $error("commit valid one edge after a paused cycle");

    end

endmodule

bind dispatch_queue backend_asserts #(
    .QUEUE_CHECKS(1'b1)
) queue_asserts (
    .clk,
    .rst_n_i,
    .count_i       (8'(count)),
    .deq_i,
    .not_empty_i   (not_empty_o),
    .pause_i       (1'b0),
    .commit_valid_i(1'b0)
);

bind backend_top backend_asserts #(
    .QUEUE_CHECKS(1'b0)
) top_asserts (
    .clk,
    .rst_n_i,
    .count_i       (8'd0),
    .deq_i         (1'b0),
    .not_empty_i   (1'b0),
    .pause_i,
    .commit_valid_i(commit_o.valid)
);

// ==== bench/backend_tb.sv ====
`include "backend_cfg.svh"

module backend_tb
    import pipeline_types::*;
();

    localparam int MODE_ALU     = 0;
    localparam int MODE_R0      = 1;
    localparam int MODE_ILLEGAL = 2;
    localparam int MODE_BP      = 3;
    localparam int MODE_FLUSH   = 4;

    localparam int N_ALU     = 40;
    localparam int N_R0      = 30;
    localparam int N_ILLEGAL = 30;
    localparam int N_BP      = 60;
    localparam int N_FLUSH   = 40;

    localparam int TOTAL_INSTS = N_ALU + N_R0 + N_ILLEGAL + N_BP + N_FLUSH;
    localparam int CYCLE_LIMIT = 4 * TOTAL_INSTS + 200;

    localparam int QUEUE_DEPTH = `BACKEND_QUEUE_DEPTH;

    logic    clk;
    logic    rst_n_i;
    logic    flush_i;
    logic    pause_i;
    logic    inst_valid_i;
    bus32_t  pc_i;
    bus32_t  inst_i;
    logic    pause_decoder_o;
    logic    excp_o;
    bus32_t  excp_pc_o;
    commit_t commit_o;

    bus32_t  lcg_state;
    bus32_t  next_pc;
    bus32_t  model_regs [32];
    bus32_t  exp_pc [$];
    bus32_t  exp_inst [$];
    logic    excp_next;
    bus32_t  excp_next_pc;
    int      model_count;
    logic    model_dec_valid;
    int      error_count;
    int      tests_run;
    int      tests_failed;
    int      cycle_count;

    backend_top dut_i (
        .clk,
        .rst_n_i,
        .flush_i,
        .pause_i,
        .inst_valid_i,
        .pc_i,
        .inst_i,
        .pause_decoder_o,
        .excp_o,
        .excp_pc_o,
        .commit_o
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= CYCLE_LIMIT) begin
                $display("timeout after %0d cycles, the DUT stopped committing", cycle_count);
                $display("SOME TESTS FAILED");
                $finish;
            end
        end
    end

    function automatic bus32_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int limit);
        return int'((lcg_next() >> 8) % 32'(limit));
    endfunction

    function automatic bus32_t model_reg(input logic [4:0] idx);
        return (idx == 5'd0) ? 32'd0 : model_regs[idx];
    endfunction

    // decoder stalls once fewer than two queue entries are free
    function automatic logic decoder_pause_expected(input int count);
        return (QUEUE_DEPTH - count) < 2;
    endfunction

    // reference ALU straight from the instruction format
    function automatic bus32_t model_exec(input bus32_t word);
        bus32_t a;
        bus32_t b;
        a = model_reg(word[22:18]);
        if (word[31:28] == 4'd7) begin
            b = {{19{word[12]}}, word[12:0]};
        end else begin
            b = model_reg(word[17:13]);
        end
        case (word[31:28])
            4'd1:    return a - b;
            4'd2:    return a & b;
            4'd3:    return a | b;
            4'd4:    return a ^ b;
            4'd5:    return a << b[4:0];
            4'd6:    return a >> b[4:0];
            default: return a + b;
        endcase
    endfunction

    function automatic bus32_t make_inst(input int mode);
        logic [3:0]  opcode;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [12:0] imm;
        opcode = 4'(rand_below(8));
        rd     = 5'(rand_below(32));
        rj     = 5'(rand_below(32));
        rk     = 5'(rand_below(32));
        imm    = 13'(lcg_next() >> 8);
        if (mode == MODE_R0) begin
            if (rand_below(2) == 0) rd = 5'd0;
            if (rand_below(2) == 0) rj = 5'd0;
            if (rand_below(2) == 0) rk = 5'd0;
        end
        if (mode == MODE_ILLEGAL && rand_below(3) == 0) begin
            opcode = 4'(8 + rand_below(8));
        end
        return {opcode, rd, rj, rk, imm};
    endfunction

    task automatic check_equal(input string what, input bus32_t actual, input bus32_t expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    // one edge, then check exception, occupancy and commit outputs
    task automatic tick();
        bus32_t pc;
        bus32_t word;
        bus32_t result;
        logic   pop;
        logic   paused;
        // occupancy model for the decoder register and the queue
        pop    = (model_count != 0) && !pause_i && !flush_i;
        paused = decoder_pause_expected(model_count);
        if (flush_i) begin
            model_count     = 0;
            model_dec_valid = 1'b0;
        end else begin
            model_count     = model_count + int'(model_dec_valid) - int'(pop);
            model_dec_valid = inst_valid_i && !paused && !inst_i[31];
        end
        @(posedge clk);
        #1;
        check_equal("excp_o", 32'(excp_o), 32'(excp_next));
        if (excp_next) begin
            check_equal("excp_pc_o", excp_pc_o, excp_next_pc);
        end
        excp_next = 1'b0;
        check_equal("pause_decoder_o", 32'(pause_decoder_o),
                    32'(decoder_pause_expected(model_count)));
        if (commit_o.valid) begin
            if (exp_pc.size() == 0) begin
                $display("unexpected commit of pc %h with nothing in flight", commit_o.pc);
                error_count++;
            end else begin
                pc     = exp_pc.pop_front();
                word   = exp_inst.pop_front();
                result = model_exec(word);
                check_equal("commit pc", commit_o.pc, pc);
                check_equal("commit rd", 32'(commit_o.rd), 32'(word[27:23]));
                check_equal("commit data", commit_o.wdata, result);
                if (word[27:23] != 5'd0) begin
                    model_regs[word[27:23]] = result;
                end
            end
        end
    endtask

    task automatic issue(input bus32_t word);
        inst_valid_i = 1'b1;
        inst_i       = word;
        pc_i         = next_pc;
        if (word[31]) begin
            excp_next    = 1'b1;
            excp_next_pc = next_pc;
        end else begin
            exp_pc.push_back(next_pc);
            exp_inst.push_back(word);
        end
        next_pc = next_pc + 32'd4;
    endtask

    task automatic drain();
        tick();
        inst_valid_i = 1'b0;
        pause_i      = 1'b0;
        flush_i      = 1'b0;
        while (exp_pc.size() != 0) begin
            tick();
        end
        repeat (4) tick();
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, error_count - errs_before);
        end
    endtask

    task automatic check_reset();
        int errs_before;
        errs_before = error_count;
        check_equal("commit valid after reset", 32'(commit_o.valid), 32'd0);
        check_equal("excp_o after reset", 32'(excp_o), 32'd0);
        check_equal("pause_decoder_o after reset", 32'(pause_decoder_o), 32'd0);
        tick();
        report_test("reset state", errs_before);
    endtask

    task automatic run_stream(input string name, input int n, input int mode);
        int     issued;
        int     burst;
        int     flushes;
        int     errs_before;
        bus32_t word;
        logic   have_word;
        logic   saw_bp;
        issued      = 0;
        burst       = 0;
        flushes     = 0;
        have_word   = 1'b0;
        saw_bp      = 1'b0;
        word        = '0;
        errs_before = error_count;
        while (issued < n) begin
            tick();
            inst_valid_i = 1'b0;
            flush_i      = 1'b0;
            pause_i      = 1'b0;
            if (pause_decoder_o) saw_bp = 1'b1;
            if (mode == MODE_BP) begin
                if (burst == 0 && rand_below(4) == 0) burst = 1 + rand_below(6);
                pause_i = (burst != 0);
                if (burst != 0) burst--;
            end
            if (mode == MODE_FLUSH && rand_below(10) == 0) begin
                // everything in flight is dropped
                flush_i = 1'b1;
                flushes++;
                exp_pc.delete();
                exp_inst.delete();
            end else begin
                if (!have_word) begin
                    word      = make_inst(mode);
                    have_word = 1'b1;
                end
                if (!pause_decoder_o && rand_below(4) != 0) begin
                    issue(word);
                    have_word = 1'b0;
                    issued++;
                end
            end
        end
        drain();
        if (mode == MODE_BP && !saw_bp) begin
            $display("back-pressure test never saw pause_decoder_o rise");
            error_count++;
        end
        if (mode == MODE_FLUSH && flushes == 0) begin
            $display("flush test ended without issuing a flush");
            error_count++;
        end
        report_test(name, errs_before);
    endtask

    initial begin
        rst_n_i         = 1'b0;
        flush_i         = 1'b0;
        pause_i         = 1'b0;
        inst_valid_i    = 1'b0;
        pc_i            = '0;
        inst_i          = '0;
        lcg_state       = 32'hba11;
        next_pc         = 32'h1c00_0000;
        excp_next       = 1'b0;
        excp_next_pc    = '0;
        model_count     = 0;
        model_dec_valid = 1'b0;
        error_count     = 0;
        tests_run       = 0;
        tests_failed    = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        check_reset();
        run_stream("alu stream", N_ALU, MODE_ALU);
        run_stream("register 0", N_R0, MODE_R0);
        run_stream("illegal opcodes", N_ILLEGAL, MODE_ILLEGAL);
        run_stream("back-pressure", N_BP, MODE_BP);
        run_stream("flush", N_FLUSH, MODE_FLUSH);

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== common/backend_cfg.svh ====
`ifndef BACKEND_CFG_SVH
`define BACKEND_CFG_SVH

// entries in the dispatch queue
`define BACKEND_QUEUE_DEPTH 4

// register index width for 32 registers
`define BACKEND_REG_ADDR_WIDTH 5

`endif

// ==== common/pipeline_types.sv ====
`include "backend_cfg.svh"

package pipeline_types;

    typedef logic [31:0] bus32_t;

    // opcode 7 maps onto ALU_ADDI with the immediate as second operand
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SLL  = 3'd5,
        ALU_SRL  = 3'd6,
        ALU_ADDI = 3'd7
    } alu_op_t;

    // decoder to execute record
    typedef struct packed {
        bus32_t                             pc;
        alu_op_t                            alu_op;
        logic [`BACKEND_REG_ADDR_WIDTH-1:0] rd;
        logic [`BACKEND_REG_ADDR_WIDTH-1:0] rj;
        logic [`BACKEND_REG_ADDR_WIDTH-1:0] rk;
        bus32_t                             imm;
        logic                               use_imm;
    } id_dispatch_t;

    // retirement trace
    typedef struct packed {
        logic                               valid;
        bus32_t                             pc;
        logic [`BACKEND_REG_ADDR_WIDTH-1:0] rd;
        bus32_t                             wdata;
    } commit_t;

endpackage

// ==== hdl/backend_top.sv ====
`include "backend_cfg.svh"

module backend_top
    import pipeline_types::*;
(
    input  logic    clk,
    input  logic    rst_n_i,

    // ctrl
    input  logic    flush_i,
    input  logic    pause_i,

    // from instruction buffer
    input  logic    inst_valid_i,
    input  bus32_t  pc_i,
    input  bus32_t  inst_i,
    output logic    pause_decoder_o,

    // exception and commit trace
    output logic    excp_o,
    output bus32_t  excp_pc_o,
    output commit_t commit_o
);

    // decoder to queue
    logic         enq;
    id_dispatch_t dispatch_rec;

    // queue to execute
    id_dispatch_t head_rec;
    logic         not_empty;
    logic         deq;

    // regfile
    logic [`BACKEND_REG_ADDR_WIDTH-1:0] raddr_a;
    logic [`BACKEND_REG_ADDR_WIDTH-1:0] raddr_b;
    bus32_t                             rdata_a;
    bus32_t                             rdata_b;
    logic                               reg_we;
    logic [`BACKEND_REG_ADDR_WIDTH-1:0] reg_waddr;
    bus32_t                             reg_wdata;

    decoder u_decoder (
        .clk,
        .rst_n_i,
        .flush_i,
        .inst_valid_i,
        .pc_i,
        .inst_i,
        .pause_decoder_i(pause_decoder_o),
        .enq_o          (enq),
        .dispatch_o     (dispatch_rec),
        .excp_o,
        .excp_pc_o
    );

    dispatch_queue #(
        .T(id_dispatch_t)
    ) u_dispatch_queue (
        .clk,
        .rst_n_i,
        .flush_i,
        .enq_i      (enq),
        .data_i     (dispatch_rec),
        .deq_i      (deq),
        .data_o     (head_rec),
        .not_empty_o(not_empty),
        .pause_decoder_o
    );

    execute u_execute (
        .clk,
        .rst_n_i,
        .flush_i,
        .pause_i,
        .not_empty_i(not_empty),
        .dispatch_i (head_rec),
        .deq_o      (deq),
        .raddr_a_o  (raddr_a),
        .raddr_b_o  (raddr_b),
        .rdata_a_i  (rdata_a),
        .rdata_b_i  (rdata_b),
        .we_o       (reg_we),
        .waddr_o    (reg_waddr),
        .wdata_o    (reg_wdata),
        .commit_o
    );

    regfile u_regfile (
        .clk,
        .rst_n_i,
        .raddr_a_i(raddr_a),
        .raddr_b_i(raddr_b),
        .rdata_a_o(rdata_a),
        .rdata_b_o(rdata_b),
        .we_i     (reg_we),
        .waddr_i  (reg_waddr),
        .wdata_i  (reg_wdata)
    );

endmodule

// ==== hdl/decoder.sv ====
module decoder
    import pipeline_types::*;
(
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         flush_i,

    // from instruction buffer
    input  logic         inst_valid_i,
    input  bus32_t       pc_i,
    input  bus32_t       inst_i,
    input  logic         pause_decoder_i,

    // to dispatch queue
    output logic         enq_o,
    output id_dispatch_t dispatch_o,

    // illegal instruction report
    output logic         excp_o,
    output bus32_t       excp_pc_o
);

    logic         accept;
    logic [3:0]   opcode;
    logic         illegal;
    id_dispatch_t decoded;

    // upstream holds off while paused, drop anything that slips through
    assign accept  = inst_valid_i && !pause_decoder_i;
    assign opcode  = inst_i[31:28];
    assign illegal = opcode[3];

    always_comb begin
        decoded.pc      = pc_i;
        decoded.alu_op  = alu_op_t'(opcode[2:0]);
        decoded.rd      = inst_i[27:23];
        decoded.rj      = inst_i[22:18];
        decoded.rk      = inst_i[17:13];
        decoded.imm     = {{19{inst_i[12]}}, inst_i[12:0]};
        decoded.use_imm = (opcode == 4'd7);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enq_o  <= 1'b0;
            excp_o <= 1'b0;
        end else if (flush_i) begin
            enq_o  <= 1'b0;
            excp_o <= 1'b0;
        end else begin
            enq_o  <= accept && !illegal;
            excp_o <= accept && illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dispatch_o <= decoded;
            excp_pc_o  <= pc_i;
        end
    end

endmodule

// ==== hdl/dispatch_queue.sv ====
`include "backend_cfg.svh"

module dispatch_queue #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic flush_i,

    input  logic enq_i,
    input  T     data_i,

    input  logic deq_i,
    output T     data_o,
    output logic not_empty_o,

    output logic pause_decoder_o
);

    localparam int DEPTH = `BACKEND_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_i) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (deq_i) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({enq_i, deq_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (enq_i && !flush_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    assign data_o      = mem[rd_ptr];
    assign not_empty_o = (count != '0);

    // keep a slot spare for the record sitting in the decoder register
    assign pause_decoder_o = (count >= CNT_W'(DEPTH - 1));

endmodule

// ==== hdl/execute.sv ====
`include "backend_cfg.svh"

module execute
    import pipeline_types::*;
(
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               flush_i,
    input  logic                               pause_i,

    // from dispatch queue
    input  logic                               not_empty_i,
    input  id_dispatch_t                       dispatch_i,
    output logic                               deq_o,

    // register file
    output logic [`BACKEND_REG_ADDR_WIDTH-1:0] raddr_a_o,
    output logic [`BACKEND_REG_ADDR_WIDTH-1:0] raddr_b_o,
    input  bus32_t                             rdata_a_i,
    input  bus32_t                             rdata_b_i,
    output logic                               we_o,
    output logic [`BACKEND_REG_ADDR_WIDTH-1:0] waddr_o,
    output bus32_t                             wdata_o,

    output commit_t                            commit_o
);

    bus32_t                             op_b;
    bus32_t                             result;
    logic                               commit_valid_q;
    bus32_t                             commit_pc_q;
    logic [`BACKEND_REG_ADDR_WIDTH-1:0] commit_rd_q;
    bus32_t                             commit_data_q;

    assign deq_o     = not_empty_i && !pause_i && !flush_i;
    assign raddr_a_o = dispatch_i.rj;
    assign raddr_b_o = dispatch_i.rk;
    assign op_b      = dispatch_i.use_imm ? dispatch_i.imm : rdata_b_i;

    always_comb begin
        case (dispatch_i.alu_op)
            ALU_SUB: result = rdata_a_i - op_b;
            ALU_AND: result = rdata_a_i & op_b;
            ALU_OR:  result = rdata_a_i | op_b;
            ALU_XOR: result = rdata_a_i ^ op_b;
            ALU_SLL: result = rdata_a_i << op_b[4:0];
            ALU_SRL: result = rdata_a_i >> op_b[4:0];
            default: result = rdata_a_i + op_b;
        endcase
    end

    // writeback lands on the popping edge, so no forwarding is needed
    assign we_o    = deq_o;
    assign waddr_o = dispatch_i.rd;
    assign wdata_o = result;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            commit_valid_q <= 1'b0;
        end else begin
            commit_valid_q <= deq_o;
        end
    end

    always_ff @(posedge clk) begin
        if (deq_o) begin
            commit_pc_q   <= dispatch_i.pc;
            commit_rd_q   <= dispatch_i.rd;
            commit_data_q <= result;
        end
    end

    always_comb begin
        commit_o.valid = commit_valid_q;
        commit_o.pc    = commit_pc_q;
        commit_o.rd    = commit_rd_q;
        commit_o.wdata = commit_data_q;
    end

endmodule

// ==== hdl/regfile.sv ====
`include "backend_cfg.svh"

module regfile
    import pipeline_types::*;
(
    input  logic                               clk,
    input  logic                               rst_n_i,

    input  logic [`BACKEND_REG_ADDR_WIDTH-1:0] raddr_a_i,
    input  logic [`BACKEND_REG_ADDR_WIDTH-1:0] raddr_b_i,
    output bus32_t                             rdata_a_o,
    output bus32_t                             rdata_b_o,

    input  logic                               we_i,
    input  logic [`BACKEND_REG_ADDR_WIDTH-1:0] waddr_i,
    input  bus32_t                             wdata_i
);

    localparam int NREGS = 1 << `BACKEND_REG_ADDR_WIDTH;

    // r0 has no storage
    bus32_t regs [1:NREGS-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module backend_tb \
    -f backend_top.f \
    --Mdir obj_dir -o backend_sim

./obj_dir/backend_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation result: pass"
else
    echo "simulation result: fail"
    exit 1
fi
